// File: rtl/cpu_pkg.sv
package cpu_pkg;

   typedef logic [31:0] word_t;      // data and address word
   typedef logic [3:0]  reg_idx_t;
   typedef logic [7:0]  flags_t;
   typedef logic [5:0]  alu_op_t;    // {ic[25:24], ic[19:16]}
   typedef logic [7:0]  ram_addr_t;  // word index into code_ram

   localparam int RAM_WORDS = 256;

   // flag bit positions
   localparam int FLAG_C = 0;   // carry
   localparam int FLAG_S = 1;   // sign
   localparam int FLAG_Z = 2;   // zero
   localparam int FLAG_V = 3;   // overflow
   localparam int FLAG_P = 4;   // pre-modify default
   localparam int FLAG_U = 5;   // up/down default

   // instruction classes in ic[27:25]
   localparam logic [2:0] INST_ALU2 = 3'd0;
   localparam logic [2:0] INST_ALU1 = 3'd1;
   localparam logic [2:0] INST_CALL = 3'd2;
   localparam logic [2:0] INST_EXT  = 3'd3;
   localparam logic [2:0] INST_ST_R = 3'd4;
   localparam logic [2:0] INST_LD_R = 3'd5;
   localparam logic [2:0] INST_ST_I = 3'd6;
   localparam logic [2:0] INST_LD_I = 3'd7;

   // low alu op in ic[19:16], 11..15 do nothing
   localparam logic [3:0] OP_ADD = 4'd0;
   localparam logic [3:0] OP_ADC = 4'd1;
   localparam logic [3:0] OP_SUB = 4'd2;
   localparam logic [3:0] OP_SBB = 4'd3;
   localparam logic [3:0] OP_AND = 4'd4;
   localparam logic [3:0] OP_OR  = 4'd5;
   localparam logic [3:0] OP_XOR = 4'd6;
   localparam logic [3:0] OP_MOV = 4'd7;
   localparam logic [3:0] OP_CMP = 4'd8;
   localparam logic [3:0] OP_SHL = 4'd9;
   localparam logic [3:0] OP_SHR = 4'd10;

   // condition field ic[31:28]
   localparam logic [3:0] COND_AL = 4'd0;
   localparam logic [3:0] COND_EQ = 4'd1;
   localparam logic [3:0] COND_NE = 4'd2;
   localparam logic [3:0] COND_CS = 4'd3;
   localparam logic [3:0] COND_CC = 4'd4;
   localparam logic [3:0] COND_MI = 4'd5;
   localparam logic [3:0] COND_PL = 4'd6;
   localparam logic [3:0] COND_VS = 4'd7;
   localparam logic [3:0] COND_VC = 4'd8;
   localparam logic [3:0] COND_NV = 4'd15;

   localparam reg_idx_t REG_PC = 4'd15;
   localparam reg_idx_t REG_LR = 4'd14;

   // encoding doubles as the clk_stat code
   typedef enum logic [2:0] {
      PH_IDLE  = 3'd0,
      PH_FETCH = 3'd1,
      PH_EXEC  = 3'd2,
      PH_MEM   = 3'd3,
      PH_WB    = 3'd4
   } phase_t;

endpackage

// File: rtl/phase_sched.sv
module phase_sched
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       run,
   output logic       phf,
   output logic       phe,
   output logic       phm,
   output logic       phw,
   output logic [2:0] clk_stat
);
   import cpu_pkg::*;

   phase_t state;
   phase_t state_nxt;

   always_comb
   begin
      state_nxt = state;
      case (state)
         PH_IDLE:  state_nxt = run ? PH_FETCH : PH_IDLE;
         PH_FETCH: state_nxt = PH_EXEC;
         PH_EXEC:  state_nxt = PH_MEM;
         PH_MEM:   state_nxt = PH_WB;
         PH_WB:    state_nxt = run ? PH_FETCH : PH_IDLE;  // stop only between instructions
         default:  state_nxt = PH_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         state <= PH_IDLE;
      else
         state <= state_nxt;
   end

   assign phf      = (state == PH_FETCH);
   assign phe      = (state == PH_EXEC);
   assign phm      = (state == PH_MEM);
   assign phw      = (state == PH_WB);
   assign clk_stat = 3'(state);

   a_phase_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0({phf, phe, phm, phw}));

endmodule

// File: rtl/alu.sv
module alu
(
   input  cpu_pkg::alu_op_t op,
   input  cpu_pkg::flags_t  fi,
   input  cpu_pkg::word_t   a,
   input  cpu_pkg::word_t   b,
   output cpu_pkg::word_t   res,
   output cpu_pkg::flags_t  fo,
   output logic             wb_en,
   output logic             flag_en
);
   import cpu_pkg::*;

   logic [3:0]  lop;     // op[5] is consumed by the operand mux in the core
   logic [4:0]  sh;
   logic [32:0] sum;     // shared adder / shifter scratch with carry bit
   logic        c;
   logic        v;

   assign lop = op[3:0];
   assign sh  = b[4:0];

   always_comb
   begin
      sum     = '0;
      res     = '0;
      c       = fi[FLAG_C];
      v       = fi[FLAG_V];
      wb_en   = 1'b1;
      flag_en = 1'b1;
      case (lop)
         OP_ADD, OP_ADC:
         begin
            sum = {1'b0, a} + {1'b0, b} + {32'd0, (lop == OP_ADC) & fi[FLAG_C]};
            res = sum[31:0];
            c   = sum[32];
            v   = (a[31] == b[31]) && (res[31] != a[31]);
         end
         OP_SUB, OP_SBB, OP_CMP:
         begin
            sum   = {1'b0, a} - {1'b0, b} - {32'd0, (lop == OP_SBB) & fi[FLAG_C]};
            res   = sum[31:0];
            c     = sum[32];                           // borrow
            v     = (a[31] != b[31]) && (res[31] != a[31]);
            wb_en = (lop != OP_CMP);
         end
         OP_AND:
         begin
            res = a & b;
            c   = 1'b0;
            v   = 1'b0;
         end
         OP_OR:
         begin
            res = a | b;
            c   = 1'b0;
            v   = 1'b0;
         end
         OP_XOR:
         begin
            res = a ^ b;
            c   = 1'b0;
            v   = 1'b0;
         end
         OP_MOV:
         begin
            res     = b;
            flag_en = 1'b0;
         end
         OP_SHL:
         begin
            sum = {1'b0, a} << sh;
            res = sum[31:0];
            if (sh != 5'd0)
               c = sum[32];                            // last bit out of the top
            v = 1'b0;
         end
         OP_SHR:
         begin
            sum = {a, 1'b0} >> sh;
            res = sum[32:1];
            if (sh != 5'd0)
               c = sum[0];
            v = 1'b0;
         end
         default:
         begin
            wb_en   = 1'b0;                            // reserved codes
            flag_en = 1'b0;
         end
      endcase
   end

   always_comb
   begin
      fo         = '0;
      fo[FLAG_C] = c;
      fo[FLAG_S] = res[31];
      fo[FLAG_Z] = (res == '0);
      fo[FLAG_V] = v;
      fo[FLAG_P] = fi[FLAG_P];  // ld/st defaults pass through
      fo[FLAG_U] = fi[FLAG_U];
   end

endmodule

// File: rtl/reg_file.sv
module reg_file
(
   input  logic              clk,
   input  logic              arst_n,
   input  cpu_pkg::reg_idx_t ra,
   input  cpu_pkg::reg_idx_t rb,
   input  cpu_pkg::reg_idx_t rd,
   output cpu_pkg::word_t    da,
   output cpu_pkg::word_t    db,
   output cpu_pkg::word_t    dd,
   input  cpu_pkg::reg_idx_t test_rsel,
   output cpu_pkg::word_t    test_reg,
   input  logic              inc_pc,
   input  logic              link_en,
   input  cpu_pkg::word_t    link_data,
   input  logic              wb_en,
   input  cpu_pkg::reg_idx_t wb_idx,
   input  cpu_pkg::word_t    wb_data
);
   import cpu_pkg::*;

   word_t regs [16];

   assign da       = regs[ra];
   assign db       = regs[rb];
   assign dd       = regs[rd];
   assign test_reg = regs[test_rsel];

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < 16; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (inc_pc)
            regs[REG_PC] <= regs[REG_PC] + 32'd1;
         if (link_en)
            regs[REG_LR] <= link_data;
         // last write wins so writeback beats the increment
         if (wb_en)
            regs[wb_idx] <= wb_data;
      end
   end

   // execute and writeback phases never overlap
   a_inc_vs_wb: assert property (@(posedge clk) disable iff (!arst_n)
      !(inc_pc && wb_en));

endmodule

// File: rtl/cpu_core.sv
module cpu_core
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              phf,
   input  logic              phe,
   input  logic              phm,
   input  logic              phw,
   output cpu_pkg::word_t    mbus_aout,
   input  cpu_pkg::word_t    mbus_din,
   output cpu_pkg::word_t    mbus_dout,
   output logic              mbus_wen,
   input  cpu_pkg::reg_idx_t test_rsel,
   output cpu_pkg::word_t    test_reg
);
   import cpu_pkg::*;

   word_t       ic;
   word_t       ic_pc;      // address the current ic came from
   word_t       link_pc;
   flags_t      flags;
   word_t       mr_data;    // load latch

   logic [3:0]  cond;
   logic [2:0]  inst;
   logic [15:0] im16;
   reg_idx_t    ra_idx;
   reg_idx_t    rb_idx;
   reg_idx_t    rd_idx;
   alu_op_t     alu_op;

   word_t       da;
   word_t       db;
   word_t       dd;
   word_t       sex_im16;
   word_t       alu_b;
   word_t       alu_res;
   flags_t      alu_fo;
   logic        alu_wb_en;
   logic        alu_flag_en;

   logic        inst_alu;
   logic        inst_call;
   logic        inst_ld;
   logic        inst_st;
   logic        inst_mem;
   logic        inst_wb;
   logic        inst_br;
   logic        ena;

   word_t       call_target;
   logic        up_down;
   logic        pre_mod;
   word_t       ldst_base;
   word_t       ldst_offset;
   word_t       ldst_addr;
   word_t       wb_data;
   reg_idx_t    wb_idx;
   logic        wb_en;
   logic        flag_wr;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         ic <= '0;
      else if (phf)
         ic <= mbus_din;
   end

   always_ff @(posedge clk)
   begin
      if (phf)
         ic_pc <= da;
      if (phm && inst_ld)
         mr_data <= mbus_din;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         flags <= '0;
      else if (flag_wr)
         flags <= alu_fo;
   end

   assign cond     = ic[31:28];
   assign inst     = ic[27:25];
   assign im16     = ic[15:0];
   assign rd_idx   = ic[23:20];
   assign rb_idx   = ic[11:8];
   // port a reads r15 outside the execute..writeback window to address the fetch
   assign ra_idx   = (phe | phm | phw) ? ic[15:12] : REG_PC;
   assign alu_op   = {ic[25:24], ic[19:16]};
   assign sex_im16 = {{16{im16[15]}}, im16};

   assign inst_alu  = (inst == INST_ALU2) || (inst == INST_ALU1);
   assign inst_call = (inst == INST_CALL);
   assign inst_ld   = (inst == INST_LD_R) || (inst == INST_LD_I);
   assign inst_st   = (inst == INST_ST_R) || (inst == INST_ST_I);
   assign inst_mem  = inst_ld | inst_st;
   assign inst_wb   = (inst_alu & alu_wb_en) | inst_ld | inst_call;
   assign inst_br   = inst_call | (inst_wb & (rd_idx == REG_PC));

   always_comb
   begin
      case (cond)
         COND_AL: ena = 1'b1;
         COND_EQ: ena = flags[FLAG_Z];
         COND_NE: ena = !flags[FLAG_Z];
         COND_CS: ena = flags[FLAG_C];
         COND_CC: ena = !flags[FLAG_C];
         COND_MI: ena = flags[FLAG_S];
         COND_PL: ena = !flags[FLAG_S];
         COND_VS: ena = flags[FLAG_V];
         COND_VC: ena = !flags[FLAG_V];
         COND_NV: ena = 1'b0;
         default: ena = 1'b1;     // spare codes run always
      endcase
   end

   // rd is the first alu operand and the destination
   assign alu_b = alu_op[5] ? sex_im16 : db;

   alu u_alu
   (
      .op      (alu_op),
      .fi      (flags),
      .a       (dd),
      .b       (alu_b),
      .res     (alu_res),
      .fo      (alu_fo),
      .wb_en   (alu_wb_en),
      .flag_en (alu_flag_en)
   );

   assign call_target = ic[24] ? dd + {{12{ic[19]}}, ic[19:0]} : {8'd0, ic[23:0]};
   assign link_pc     = ic_pc + 32'd1;   // r15 after the execute increment

   // immediate forms carry u/p in the word, register forms use the flags
   assign up_down     = ic[26] ? ic[15] : flags[FLAG_U];
   assign pre_mod     = ic[26] ? ic[14] : flags[FLAG_P];
   assign ldst_base   = pre_mod ? (up_down ? da + 32'd1 : da - 32'd1) : da;
   assign ldst_offset = ic[26] ? sex_im16 : db;
   assign ldst_addr   = ldst_base + ldst_offset;

   assign wb_data = inst_call ? call_target :
                    inst_ld   ? mr_data     :
                                alu_res;
   assign wb_idx  = inst_call ? REG_PC : rd_idx;
   assign wb_en   = phw & ena & inst_wb;
   assign flag_wr = phw & ena & inst_alu & alu_flag_en;

   reg_file u_reg_file
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .ra        (ra_idx),
      .rb        (rb_idx),
      .rd        (rd_idx),
      .da        (da),
      .db        (db),
      .dd        (dd),
      .test_rsel (test_rsel),
      .test_reg  (test_reg),
      .inc_pc    (phe),
      .link_en   (phm & ena & inst_call),
      .link_data (link_pc),
      .wb_en     (wb_en),
      .wb_idx    (wb_idx),
      .wb_data   (wb_data)
   );

   assign mbus_aout = phe ? (inst_ld ? ldst_addr : ic_pc)              :
                      phm ? (inst_mem ? ldst_addr : link_pc)           :
                      phw ? ((inst_br & ena) ? wb_data : link_pc)      :
                            da;                              // fetch or idle
   assign mbus_dout = dd;
   assign mbus_wen  = phm & ena & inst_st;

   // store strobe lands in the memory phase of its own instruction
   a_wen_in_mem: assert property (@(posedge clk) disable iff (!arst_n)
      mbus_wen |-> phm && $past(phf, 2));

endmodule

// File: rtl/code_ram.sv
module code_ram
(
   input  logic               clk,
   input  logic               run,
   input  cpu_pkg::ram_addr_t addr,
   output cpu_pkg::word_t     rdata,
   input  cpu_pkg::word_t     wdata,
   input  logic               wen,
   input  logic               load_en,
   input  cpu_pkg::ram_addr_t load_addr,
   input  cpu_pkg::word_t     load_data
);
   import cpu_pkg::*;

   word_t mem [RAM_WORDS];

   assign rdata = mem[addr];   // same-cycle read for fetch and load

   always_ff @(posedge clk)
   begin
      if (run)
      begin
         if (wen)
            mem[addr] <= wdata;
      end
      else if (load_en)
      begin
         mem[load_addr] <= load_data;   // preload while the core is halted
      end
   end

endmodule

// File: rtl/sys_top.sv
module sys_top
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               run,
   input  logic               load_en,
   input  cpu_pkg::ram_addr_t load_addr,
   input  cpu_pkg::word_t     load_data,
   input  cpu_pkg::reg_idx_t  test_rsel,
   output cpu_pkg::word_t     test_reg,
   output logic [2:0]         clk_stat,
   output cpu_pkg::word_t     bus_addr,
   output cpu_pkg::word_t     bus_wdata,
   output logic               bus_wen
);
   import cpu_pkg::*;

   logic  phf;
   logic  phe;
   logic  phm;
   logic  phw;
   word_t mbus_aout;
   word_t mbus_din;
   word_t mbus_dout;
   logic  mbus_wen;

   phase_sched u_phase_sched
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .run      (run),
      .phf      (phf),
      .phe      (phe),
      .phm      (phm),
      .phw      (phw),
      .clk_stat (clk_stat)
   );

   cpu_core u_cpu_core
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .phf       (phf),
      .phe       (phe),
      .phm       (phm),
      .phw       (phw),
      .mbus_aout (mbus_aout),
      .mbus_din  (mbus_din),
      .mbus_dout (mbus_dout),
      .mbus_wen  (mbus_wen),
      .test_rsel (test_rsel),
      .test_reg  (test_reg)
   );

   code_ram u_code_ram
   (
      .clk       (clk),
      .run       (run),
      .addr      (mbus_aout[7:0]),   // word index, upper bits ignored
      .rdata     (mbus_din),
      .wdata     (mbus_dout),
      .wen       (mbus_wen),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

   assign bus_addr  = mbus_aout;
   assign bus_wdata = mbus_dout;
   assign bus_wen   = mbus_wen;

endmodule

// File: verif/tb_sys_top.sv
module tb_sys_top;
   import cpu_pkg::*;

   logic       clk;
   logic       arst_n;
   logic       run;
   logic       load_en;
   ram_addr_t  load_addr;
   word_t      load_data;
   reg_idx_t   test_rsel;
   word_t      test_reg;
   logic [2:0] clk_stat;
   word_t      bus_addr;
   word_t      bus_wdata;
   logic       bus_wen;

   word_t  prog [RAM_WORDS];
   int     n;
   int     halt_addr;
   word_t  mreg [16];        // instruction-level model state
   word_t  mmem [RAM_WORDS];
   flags_t mflags;
   logic   exp_wen;          // store expected from the pending instruction
   word_t  exp_addr;
   word_t  exp_data;
   word_t  exp_reg;
   int     seed;
   int     errors;
   int     other_errors;
   int     cycles;
   int     limit;

   sys_top DUT
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .run       (run),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .test_rsel (test_rsel),
      .test_reg  (test_reg),
      .clk_stat  (clk_stat),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_wen   (bus_wen)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic word_t sext16(input logic [15:0] v);
      return {{16{v[15]}}, v};
   endfunction

   function automatic logic cond_ok(input logic [3:0] c, input flags_t f);
      case (c)
         COND_EQ: return f[FLAG_Z];
         COND_NE: return !f[FLAG_Z];
         COND_CS: return f[FLAG_C];
         COND_CC: return !f[FLAG_C];
         COND_MI: return f[FLAG_S];
         COND_PL: return !f[FLAG_S];
         COND_VS: return f[FLAG_V];
         COND_VC: return !f[FLAG_V];
         COND_NV: return 1'b0;
         default: return 1'b1;
      endcase
   endfunction

   task automatic alu_model(input logic [3:0] op, input flags_t fi, input word_t a,
                            input word_t b, output word_t r, output flags_t fo,
                            output logic wb, output logic fe);
      logic        c;
      logic        v;
      logic [32:0] cin;
      logic [63:0] wide;
      int          s;
      c    = fi[FLAG_C];
      v    = fi[FLAG_V];
      wb   = 1'b1;
      fe   = 1'b1;
      r    = '0;
      s    = int'(b[4:0]);
      cin  = ((op == OP_ADC) || (op == OP_SBB)) ? {32'd0, fi[FLAG_C]} : 33'd0;
      wide = '0;
      case (op)
         OP_ADD, OP_ADC:
         begin
            wide = {32'd0, a} + {32'd0, b} + {31'd0, cin};
            r    = wide[31:0];
            c    = wide[32];
            v    = (a[31] == b[31]) && (r[31] != a[31]);
         end
         OP_SUB, OP_SBB, OP_CMP:
         begin
            r  = a - b - cin[31:0];
            c  = ({1'b0, a} < ({1'b0, b} + cin));   // borrow out
            v  = (a[31] != b[31]) && (r[31] != a[31]);
            wb = (op != OP_CMP);
         end
         OP_AND, OP_OR, OP_XOR:
         begin
            r = (op == OP_AND) ? (a & b) : (op == OP_OR) ? (a | b) : (a ^ b);
            c = 1'b0;
            v = 1'b0;
         end
         OP_MOV:
         begin
            r  = b;
            fe = 1'b0;
         end
         OP_SHL, OP_SHR:
         begin
            r = (op == OP_SHL) ? (a << s) : (a >> s);
            if (s != 0)
               c = (op == OP_SHL) ? a[32 - s] : a[s - 1];
            v = 1'b0;
         end
         default:
         begin
            wb = 1'b0;
            fe = 1'b0;
         end
      endcase
      fo         = fi & 8'h30;
      fo[FLAG_C] = c;
      fo[FLAG_S] = r[31];
      fo[FLAG_Z] = (r == '0);
      fo[FLAG_V] = v;
   endtask

   function automatic word_t ldst_address(input word_t ic);
      logic  up;
      logic  pre;
      word_t base;
      up   = ic[26] ? ic[15] : mflags[FLAG_U];
      pre  = ic[26] ? ic[14] : mflags[FLAG_P];
      base = mreg[ic[15:12]];
      if (pre)
         base = up ? base + 32'd1 : base - 32'd1;
      return base + (ic[26] ? sext16(ic[15:0]) : mreg[ic[11:8]]);
   endfunction

   task automatic predict_store();
      word_t ic;
      ic       = mmem[mreg[REG_PC][7:0]];
      exp_wen  = cond_ok(ic[31:28], mflags) &&
                 ((ic[27:25] == INST_ST_R) || (ic[27:25] == INST_ST_I));
      exp_addr = ldst_address(ic);
      exp_data = mreg[ic[23:20]];
   endtask

   task automatic model_step();
      word_t    ic;
      word_t    pc;
      word_t    r;
      word_t    addr;
      flags_t   fo;
      logic     wb;
      logic     fe;
      logic     ena;
      reg_idx_t rd;
      pc  = mreg[REG_PC];
      ic  = mmem[pc[7:0]];
      rd  = ic[23:20];
      mreg[REG_PC] = pc + 32'd1;
      ena = cond_ok(ic[31:28], mflags);
      case (ic[27:25])
         INST_ALU2, INST_ALU1:
         begin
            alu_model(ic[19:16], mflags, mreg[rd], ic[25] ? sext16(ic[15:0]) : mreg[ic[11:8]],
                      r, fo, wb, fe);
            if (ena && wb)
               mreg[rd] = r;
            if (ena && fe)
               mflags = fo;
         end
         INST_CALL:
         begin
            if (ena)
            begin
               mreg[REG_LR] = pc + 32'd1;
               mreg[REG_PC] = ic[24] ? mreg[rd] + {{12{ic[19]}}, ic[19:0]} : {8'd0, ic[23:0]};
            end
         end
         INST_ST_R, INST_ST_I, INST_LD_R, INST_LD_I:
         begin
            addr = ldst_address(ic);
            if (ena && ic[25])
               mreg[rd] = mmem[addr[7:0]];
            else if (ena)
               mmem[addr[7:0]] = mreg[rd];
         end
         default:
         begin
         end
      endcase
   endtask

   task automatic emit(input word_t w);
      prog[n] = w;
      n++;
   endtask

   function automatic word_t alu2(input logic [3:0] c, input logic [3:0] op,
                                  input reg_idx_t rd, input reg_idx_t rb);
      return {c, INST_ALU2, 1'b0, rd, op, 4'd0, rb, 8'd0};
   endfunction

   function automatic word_t alu1(input logic [3:0] c, input logic [3:0] op,
                                  input reg_idx_t rd, input logic [15:0] im);
      return {c, INST_ALU1, 1'b0, rd, op, im};
   endfunction

   // immediate forms take u/p from the top two bits of ra
   function automatic word_t ldst(input logic [3:0] c, input logic [2:0] cls, input reg_idx_t rd,
                                  input reg_idx_t ra, input logic [11:0] low);
      return {c, cls, 1'b0, rd, 4'd0, ra, low};
   endfunction

   function automatic logic [15:0] rnd16();
      return 16'($random(seed));
   endfunction

   task automatic build_program();
      int t;
      n = 0;
      emit(alu1(COND_AL, OP_MOV, 4'd6, 16'h00e0));
      emit(alu1(COND_AL, OP_MOV, 4'd10, 16'h00e0));
      emit(alu1(COND_AL, OP_MOV, 4'd7, 16'h00e0));
      emit(alu1(COND_AL, OP_MOV, 4'd2, rnd16()));
      for (int op = 0; op < 16; op++)
      begin
         emit(alu1(COND_AL, OP_MOV, 4'd3, rnd16()));
         emit(alu2(COND_AL, 4'(op), 4'd3, 4'd2));
         emit(alu1(COND_AL, OP_MOV, 4'd4, rnd16()));
         emit(alu1(COND_AL, 4'(op), 4'd4, rnd16()));
      end
      for (int c = 0; c < 16; c++)
      begin
         emit(alu1(COND_AL, OP_MOV, 4'd1, rnd16()));
         emit(alu2(COND_AL, OP_CMP, 4'd1, 4'd2));
         emit(alu1(4'(c), OP_ADD, 4'd5, rnd16()));
         emit(ldst(4'(c), INST_ST_I, 4'd5, 4'd6, 12'(c)));
      end
      for (int i = 0; i < 4; i++)
      begin
         emit(alu1(COND_AL, OP_MOV, 4'd8, rnd16() & 16'h001f));
         emit(alu1(COND_AL, OP_MOV, 4'd5, rnd16()));
         emit(ldst(COND_AL, INST_ST_R, 4'd5, 4'd7, {4'd8, 8'd0}));
         emit(ldst(COND_AL, INST_LD_R, 4'd9, 4'd7, {4'd8, 8'd0}));
         emit(ldst(COND_AL, INST_ST_I, 4'd9, 4'd6, 12'h010 + 12'(i)));
         emit(ldst(COND_AL, INST_LD_I, 4'd11, 4'd6, 12'h010 + 12'(i)));
         emit(ldst(COND_AL, INST_LD_I, 4'd11, 4'd10, 12'(rnd16()) & 12'h01f));
      end
      t = n + 2;
      emit({COND_AL, INST_CALL, 1'b0, 24'(t)});
      emit(alu1(COND_AL, OP_MOV, 4'd13, 16'hdead));    // skipped
      t = n + 3;
      emit(alu1(COND_AL, OP_MOV, 4'd12, 16'(t - 5)));
      emit({COND_AL, INST_CALL, 1'b1, 4'd12, 20'd5});
      emit(alu1(COND_AL, OP_MOV, 4'd13, 16'hbeef));    // skipped
      t = n + 2;
      emit(alu1(COND_AL, OP_MOV, REG_PC, 16'(t)));
      emit(alu1(COND_AL, OP_MOV, 4'd13, 16'hf00d));    // skipped
      halt_addr = n;
      emit(alu1(COND_NV, OP_MOV, 4'd13, 16'h0001));
      emit(alu1(COND_NV, OP_MOV, 4'd13, 16'h0002));
   endtask

   assign exp_reg = ((test_rsel == REG_PC) && (clk_stat == 3'd3)) ? mreg[REG_PC] + 32'd1
                                                                   : mreg[test_rsel];

   always @(negedge clk)
   begin
      if (arst_n && (clk_stat == 3'd4))
      begin
         model_step();
         predict_store();
      end
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= limit)
      begin
         $display("timeout after %0d cycles, program did not finish", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   a_reg: assert property (@(posedge clk) disable iff (!arst_n)
      (clk_stat != 3'd4) |-> (test_reg == exp_reg))
      else
      begin
         $display("MISMATCH t=%0t test_reg[r%0d] exp %h got %h", $time, test_rsel,
                  exp_reg, test_reg);
         errors++;
      end

   a_fetch: assert property (@(posedge clk) disable iff (!arst_n)
      (clk_stat == 3'd1) |-> (bus_addr == mreg[REG_PC]))
      else
      begin
         $display("MISMATCH t=%0t bus_addr(fetch) exp %h got %h", $time,
                  mreg[REG_PC], bus_addr);
         errors++;
      end

   a_store_wen: assert property (@(posedge clk) disable iff (!arst_n)
      bus_wen == ((clk_stat == 3'd3) && exp_wen))
      else
      begin
         $display("MISMATCH t=%0t bus_wen exp %b got %b", $time,
                  (clk_stat == 3'd3) && exp_wen, bus_wen);
         errors++;
      end

   a_store_data: assert property (@(posedge clk) disable iff (!arst_n)
      bus_wen |-> ((bus_addr == exp_addr) && (bus_wdata == exp_data)))
      else
      begin
         $display("MISMATCH t=%0t bus_addr/bus_wdata exp %h/%h got %h/%h", $time,
                  exp_addr, exp_data, bus_addr, bus_wdata);
         errors++;
      end

   a_phase_step: assert property (@(posedge clk) disable iff (!arst_n)
      ((clk_stat inside {3'd1, 3'd2, 3'd3}) |=> (clk_stat == $past(clk_stat) + 3'd1)))
      else
      begin
         $display("t=%0t phase did not advance to the next step", $time);
         other_errors++;
      end

   a_phase_restart: assert property (@(posedge clk) disable iff (!arst_n)
      (((clk_stat == 3'd4) || (clk_stat == 3'd0)) && run) |=> (clk_stat == 3'd1))
      else
      begin
         $display("t=%0t no fetch followed while run was high", $time);
         other_errors++;
      end

   a_idle: assert property (@(posedge clk) disable iff (!arst_n)
      (((clk_stat == 3'd4) || (clk_stat == 3'd0)) && !run) |=> (clk_stat == 3'd0))
      else
      begin
         $display("t=%0t core did not stay idle while run was low", $time);
         other_errors++;
      end

   initial
   begin
      seed         = 25;
      errors       = 0;
      other_errors = 0;
      cycles       = 0;
      arst_n       = 1'b0;
      run          = 1'b0;
      load_en      = 1'b0;
      load_addr    = '0;
      load_data    = '0;
      test_rsel    = '0;
      mflags       = '0;
      for (int i = 0; i < 16; i++)
         mreg[i] = '0;
      for (int a = 0; a < RAM_WORDS; a++)
         prog[a] = {8'(a), ~8'(a), 8'(a) ^ 8'ha5, 8'(a) + 8'h3c};   // fill pattern
      build_program();
      for (int a = 0; a < RAM_WORDS; a++)
         mmem[a] = prog[a];
      limit = n * 4 * 2 + RAM_WORDS + 5 + 20;
      predict_store();
      repeat (5) @(posedge clk);
      #1 arst_n = 1'b1;
      for (int a = 0; a < RAM_WORDS; a++)
      begin
         load_en   = 1'b1;
         load_addr = 8'(a);
         load_data = prog[a];
         @(posedge clk);
         #1;
         test_rsel = test_rsel + 4'd1;
      end
      load_en = 1'b0;
      run     = 1'b1;
      while (mreg[REG_PC] != word_t'(halt_addr))
      begin
         @(posedge clk);
         #1 test_rsel = test_rsel + 4'd1;
      end
      run = 1'b0;
      while (clk_stat != 3'd0)
      begin
         @(posedge clk);
         #1 test_rsel = test_rsel + 4'd1;
      end
      repeat (16)
      begin
         @(posedge clk);
         #1 test_rsel = test_rsel + 4'd1;
      end
      $display("errors: %0d mismatches, %0d other failures", errors, other_errors);
      if ((errors == 0) && (other_errors == 0))
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: sys_top.f
rtl/cpu_pkg.sv
rtl/phase_sched.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/cpu_core.sv
rtl/code_ram.sv
rtl/sys_top.sv
verif/tb_sys_top.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -j 0 -f sys_top.f \
		--top-module tb_sys_top -Mdir obj_dir -o sim
	./obj_dir/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
